// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes, instr[31:26]
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // special group function codes, instr[5:0]

    // shifts by the shamt field
    localparam funct_t F_SLL  = 6'b000000;
    localparam funct_t F_SRL  = 6'b000010;
    localparam funct_t F_SRA  = 6'b000011;

    // shifts by rs[4:0]
    localparam funct_t F_SLLV = 6'b000100;
    localparam funct_t F_SRLV = 6'b000110;
    localparam funct_t F_SRAV = 6'b000111;

    // add and subtract, trapping and non-trapping
    localparam funct_t F_ADD  = 6'b100000;
    localparam funct_t F_ADDU = 6'b100001;
    localparam funct_t F_SUB  = 6'b100010;
    localparam funct_t F_SUBU = 6'b100011;

    // bitwise logic
    localparam funct_t F_AND  = 6'b100100;
    localparam funct_t F_OR   = 6'b100101;
    localparam funct_t F_XOR  = 6'b100110;
    localparam funct_t F_NOR  = 6'b100111;

    // set on less than
    localparam funct_t F_SLT  = 6'b101010;
    localparam funct_t F_SLTU = 6'b101011;

endpackage

// ==== exec_ctrl_pkg.sv ====
package exec_ctrl_pkg;

    // operation performed by the execute stage
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_func_e;

    // source of the second ALU operand
    typedef enum logic [0:0] {
        OPB_REG = 1'b0,
        OPB_IMM = 1'b1
    } operand_b_sel_e;

endpackage

// ==== instr_decode.sv ====
module instr_decode (
    input  logic                     instr_valid,
    input  mips_isa_pkg::word_t      instr,
    input  mips_isa_pkg::word_t      rs_data,
    input  mips_isa_pkg::word_t      rt_data,
    input  logic                     ex_write,
    input  mips_isa_pkg::reg_addr_t  ex_dest,
    input  mips_isa_pkg::word_t      ex_result,
    output mips_isa_pkg::reg_addr_t  rs_addr,
    output mips_isa_pkg::reg_addr_t  rt_addr,
    output logic                     dec_valid,
    output exec_ctrl_pkg::alu_func_e dec_func,
    output mips_isa_pkg::word_t      dec_opa,
    output mips_isa_pkg::word_t      dec_opb,
    output mips_isa_pkg::shamt_t     dec_shamt,
    output mips_isa_pkg::reg_addr_t  dec_dest,
    output logic                     dec_regwrite,
    output logic                     dec_ov_check,
    output logic                     dec_reserved
);

    mips_isa_pkg::opcode_t         opcode;
    mips_isa_pkg::funct_t          funct;
    mips_isa_pkg::reg_addr_t       rd_addr;
    mips_isa_pkg::shamt_t          shamt_field;
    mips_isa_pkg::imm_t            imm;
    mips_isa_pkg::word_t           imm_ext;
    mips_isa_pkg::word_t           rs_val;
    mips_isa_pkg::word_t           rt_val;
    exec_ctrl_pkg::operand_b_sel_e b_sel;
    logic                          zero_ext;
    logic                          dest_rd;
    logic                          shamt_var;

    assign opcode      = instr[31:26];
    assign rs_addr     = instr[25:21];
    assign rt_addr     = instr[20:16];
    assign rd_addr     = instr[15:11];
    assign shamt_field = instr[10:6];
    assign funct       = instr[5:0];
    assign imm         = instr[15:0];

    always_comb begin
        dec_func     = exec_ctrl_pkg::ALU_ADD;
        b_sel        = exec_ctrl_pkg::OPB_REG;
        zero_ext     = 1'b0;
        dest_rd      = 1'b0;
        shamt_var    = 1'b0;
        dec_regwrite = 1'b0;
        dec_ov_check = 1'b0;
        dec_reserved = 1'b0;
        case (opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                dest_rd      = 1'b1;
                dec_regwrite = 1'b1;
                case (funct)
                    mips_isa_pkg::F_ADD: begin
                        dec_func     = exec_ctrl_pkg::ALU_ADD;
                        dec_ov_check = 1'b1;
                    end
                    mips_isa_pkg::F_ADDU: dec_func = exec_ctrl_pkg::ALU_ADD;
                    mips_isa_pkg::F_SUB: begin
                        dec_func     = exec_ctrl_pkg::ALU_SUB;
                        dec_ov_check = 1'b1;
                    end
                    mips_isa_pkg::F_SUBU: dec_func = exec_ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::F_AND:  dec_func = exec_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::F_OR:   dec_func = exec_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::F_XOR:  dec_func = exec_ctrl_pkg::ALU_XOR;
                    mips_isa_pkg::F_NOR:  dec_func = exec_ctrl_pkg::ALU_NOR;
                    mips_isa_pkg::F_SLT:  dec_func = exec_ctrl_pkg::ALU_SLT;
                    mips_isa_pkg::F_SLTU: dec_func = exec_ctrl_pkg::ALU_SLTU;
                    mips_isa_pkg::F_SLL:  dec_func = exec_ctrl_pkg::ALU_SLL;
                    mips_isa_pkg::F_SRL:  dec_func = exec_ctrl_pkg::ALU_SRL;
                    mips_isa_pkg::F_SRA:  dec_func = exec_ctrl_pkg::ALU_SRA;
                    mips_isa_pkg::F_SLLV: begin
                        dec_func  = exec_ctrl_pkg::ALU_SLL;
                        shamt_var = 1'b1;
                    end
                    mips_isa_pkg::F_SRLV: begin
                        dec_func  = exec_ctrl_pkg::ALU_SRL;
                        shamt_var = 1'b1;
                    end
                    mips_isa_pkg::F_SRAV: begin
                        dec_func  = exec_ctrl_pkg::ALU_SRA;
                        shamt_var = 1'b1;
                    end
                    default: begin
                        dec_regwrite = 1'b0;
                        dec_reserved = 1'b1;
                    end
                endcase
            end
            mips_isa_pkg::OP_ADDI: begin
                dec_func     = exec_ctrl_pkg::ALU_ADD;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                dec_regwrite = 1'b1;
                dec_ov_check = 1'b1;
            end
            mips_isa_pkg::OP_ADDIU: begin
                dec_func     = exec_ctrl_pkg::ALU_ADD;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                dec_regwrite = 1'b1;
            end
            mips_isa_pkg::OP_SLTI: begin
                dec_func     = exec_ctrl_pkg::ALU_SLT;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                dec_regwrite = 1'b1;
            end
            // sltiu still sign-extends, only the compare is unsigned
            mips_isa_pkg::OP_SLTIU: begin
                dec_func     = exec_ctrl_pkg::ALU_SLTU;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                dec_regwrite = 1'b1;
            end
            mips_isa_pkg::OP_ANDI: begin
                dec_func     = exec_ctrl_pkg::ALU_AND;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                zero_ext     = 1'b1;
                dec_regwrite = 1'b1;
            end
            mips_isa_pkg::OP_ORI: begin
                dec_func     = exec_ctrl_pkg::ALU_OR;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                zero_ext     = 1'b1;
                dec_regwrite = 1'b1;
            end
            mips_isa_pkg::OP_XORI: begin
                dec_func     = exec_ctrl_pkg::ALU_XOR;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                zero_ext     = 1'b1;
                dec_regwrite = 1'b1;
            end
            mips_isa_pkg::OP_LUI: begin
                dec_func     = exec_ctrl_pkg::ALU_LUI;
                b_sel        = exec_ctrl_pkg::OPB_IMM;
                dec_regwrite = 1'b1;
            end
            default: dec_reserved = 1'b1;
        endcase
    end

    assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    // ex_write is never set for r0, so a match here is always a real register
    assign rs_val = (ex_write && ex_dest == rs_addr) ? ex_result : rs_data;
    assign rt_val = (ex_write && ex_dest == rt_addr) ? ex_result : rt_data;

    assign dec_valid = instr_valid;
    assign dec_opa   = rs_val;
    assign dec_opb   = (b_sel == exec_ctrl_pkg::OPB_IMM) ? imm_ext : rt_val;
    assign dec_shamt = shamt_var ? rs_val[4:0] : shamt_field;
    assign dec_dest  = dest_rd ? rd_addr : rt_addr;

endmodule

// ==== alu_execute.sv ====
module alu_execute (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     dec_valid,
    input  exec_ctrl_pkg::alu_func_e dec_func,
    input  mips_isa_pkg::word_t      dec_opa,
    input  mips_isa_pkg::word_t      dec_opb,
    input  mips_isa_pkg::shamt_t     dec_shamt,
    input  mips_isa_pkg::reg_addr_t  dec_dest,
    input  logic                     dec_regwrite,
    input  logic                     dec_ov_check,
    input  logic                     dec_reserved,
    output logic                     ex_valid,
    output mips_isa_pkg::reg_addr_t  ex_dest,
    output mips_isa_pkg::word_t      ex_result,
    output logic                     ex_write,
    output logic                     ex_overflow,
    output logic                     ex_reserved
);

    logic                     valid_q;
    logic                     regwrite_q;
    logic                     ov_check_q;
    logic                     reserved_q;
    exec_ctrl_pkg::alu_func_e func_q;
    mips_isa_pkg::word_t      opa_q;
    mips_isa_pkg::word_t      opb_q;
    mips_isa_pkg::shamt_t     shamt_q;
    mips_isa_pkg::reg_addr_t  dest_q;
    mips_isa_pkg::word_t      sum;
    mips_isa_pkg::word_t      diff;
    logic                     add_ovf;
    logic                     sub_ovf;
    logic                     ovf;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= 1'b0;
            regwrite_q <= 1'b0;
            ov_check_q <= 1'b0;
            reserved_q <= 1'b0;
        end else begin
            valid_q    <= dec_valid;
            regwrite_q <= dec_regwrite;
            ov_check_q <= dec_ov_check;
            reserved_q <= dec_reserved;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            func_q  <= dec_func;
            opa_q   <= dec_opa;
            opb_q   <= dec_opb;
            shamt_q <= dec_shamt;
            dest_q  <= dec_dest;
        end
    end

    assign sum  = opa_q + opb_q;
    assign diff = opa_q - opb_q;

    // operands of equal sign, result of the other sign
    assign add_ovf = (opa_q[31] == opb_q[31]) && (sum[31] != opa_q[31]);
    assign sub_ovf = (opa_q[31] != opb_q[31]) && (diff[31] != opa_q[31]);

    always_comb begin
        case (func_q)
            exec_ctrl_pkg::ALU_ADD:  ex_result = sum;
            exec_ctrl_pkg::ALU_SUB:  ex_result = diff;
            exec_ctrl_pkg::ALU_AND:  ex_result = opa_q & opb_q;
            exec_ctrl_pkg::ALU_OR:   ex_result = opa_q | opb_q;
            exec_ctrl_pkg::ALU_XOR:  ex_result = opa_q ^ opb_q;
            exec_ctrl_pkg::ALU_NOR:  ex_result = ~(opa_q | opb_q);
            exec_ctrl_pkg::ALU_SLT:  ex_result = {31'd0, $signed(opa_q) < $signed(opb_q)};
            exec_ctrl_pkg::ALU_SLTU: ex_result = {31'd0, opa_q < opb_q};
            exec_ctrl_pkg::ALU_SLL:  ex_result = opb_q << shamt_q;
            exec_ctrl_pkg::ALU_SRL:  ex_result = opb_q >> shamt_q;
            exec_ctrl_pkg::ALU_SRA:  ex_result = $signed(opb_q) >>> shamt_q;
            exec_ctrl_pkg::ALU_LUI:  ex_result = {opb_q[15:0], 16'h0000};
            default:                 ex_result = '0;
        endcase
    end

    always_comb begin
        ovf = 1'b0;
        if (ov_check_q) begin
            ovf = (func_q == exec_ctrl_pkg::ALU_SUB) ? sub_ovf : add_ovf;
        end
    end

    assign ex_valid    = valid_q;
    assign ex_dest     = dest_q;
    assign ex_overflow = valid_q & ovf;
    assign ex_reserved = valid_q & reserved_q;
    assign ex_write    = valid_q & regwrite_q & ~ovf & ~reserved_q & (dest_q != '0);

endmodule

// ==== reg_writeback.sv ====
module reg_writeback (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ex_valid,
    input  mips_isa_pkg::reg_addr_t ex_dest,
    input  mips_isa_pkg::word_t     ex_result,
    input  logic                    ex_write,
    input  logic                    ex_overflow,
    input  logic                    ex_reserved,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    output mips_isa_pkg::word_t     rs_data,
    output mips_isa_pkg::word_t     rt_data,
    output logic                    wb_valid,
    output mips_isa_pkg::reg_addr_t wb_reg,
    output mips_isa_pkg::word_t     wb_data,
    output logic                    exc_reserved,
    output logic                    exc_overflow
);

    // r0 has no storage, it is hardwired to zero on read
    mips_isa_pkg::word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_write) begin
            regs[ex_dest] <= ex_result;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    // one pulse per executed instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid     <= 1'b0;
            exc_reserved <= 1'b0;
            exc_overflow <= 1'b0;
        end else begin
            wb_valid     <= ex_valid & ~ex_reserved & ~ex_overflow;
            exc_reserved <= ex_reserved;
            exc_overflow <= ex_overflow;
        end
    end

    // a write to r0 still reports its computed data
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_reg  <= ex_dest;
            wb_data <= ex_result;
        end
    end

endmodule

// ==== int_exec_core.sv ====
module int_exec_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    input  mips_isa_pkg::word_t     instr,
    output logic                    wb_valid,
    output mips_isa_pkg::reg_addr_t wb_reg,
    output mips_isa_pkg::word_t     wb_data,
    output logic                    exc_reserved,
    output logic                    exc_overflow
);

    mips_isa_pkg::reg_addr_t  rs_addr;
    mips_isa_pkg::reg_addr_t  rt_addr;
    mips_isa_pkg::word_t      rs_data;
    mips_isa_pkg::word_t      rt_data;

    logic                     dec_valid;
    exec_ctrl_pkg::alu_func_e dec_func;
    mips_isa_pkg::word_t      dec_opa;
    mips_isa_pkg::word_t      dec_opb;
    mips_isa_pkg::shamt_t     dec_shamt;
    mips_isa_pkg::reg_addr_t  dec_dest;
    logic                     dec_regwrite;
    logic                     dec_ov_check;
    logic                     dec_reserved;

    logic                     ex_valid;
    mips_isa_pkg::reg_addr_t  ex_dest;
    mips_isa_pkg::word_t      ex_result;
    logic                     ex_write;
    logic                     ex_overflow;
    logic                     ex_reserved;

    instr_decode instr_decode_inst (
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .ex_write     (ex_write),
        .ex_dest      (ex_dest),
        .ex_result    (ex_result),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .dec_valid    (dec_valid),
        .dec_func     (dec_func),
        .dec_opa      (dec_opa),
        .dec_opb      (dec_opb),
        .dec_shamt    (dec_shamt),
        .dec_dest     (dec_dest),
        .dec_regwrite (dec_regwrite),
        .dec_ov_check (dec_ov_check),
        .dec_reserved (dec_reserved)
    );

    alu_execute alu_execute_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .dec_valid    (dec_valid),
        .dec_func     (dec_func),
        .dec_opa      (dec_opa),
        .dec_opb      (dec_opb),
        .dec_shamt    (dec_shamt),
        .dec_dest     (dec_dest),
        .dec_regwrite (dec_regwrite),
        .dec_ov_check (dec_ov_check),
        .dec_reserved (dec_reserved),
        .ex_valid     (ex_valid),
        .ex_dest      (ex_dest),
        .ex_result    (ex_result),
        .ex_write     (ex_write),
        .ex_overflow  (ex_overflow),
        .ex_reserved  (ex_reserved)
    );

    reg_writeback reg_writeback_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_valid     (ex_valid),
        .ex_dest      (ex_dest),
        .ex_result    (ex_result),
        .ex_write     (ex_write),
        .ex_overflow  (ex_overflow),
        .ex_reserved  (ex_reserved),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .exc_reserved (exc_reserved),
        .exc_overflow (exc_overflow)
    );

endmodule

// ==== exec_checker.sv ====
module exec_checker (
    input  logic                    clk,
    input  logic                    wb_valid,
    input  mips_isa_pkg::reg_addr_t wb_reg,
    input  mips_isa_pkg::word_t     wb_data,
    input  logic                    exc_reserved,
    input  logic                    exc_overflow,
    input  logic                    exp_push,
    input  logic [7:0]              exp_kind,
    input  mips_isa_pkg::reg_addr_t exp_reg,
    input  mips_isa_pkg::word_t     exp_data,
    output int                      done_count,
    output int                      err_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]              kind_q [$];
    mips_isa_pkg::reg_addr_t reg_q [$];
    mips_isa_pkg::word_t     data_q [$];

    // outputs are registered in the DUT, so the values before the edge are stable
    always @(posedge clk) begin
        logic [7:0]              kind;
        logic [7:0]              want_kind;
        mips_isa_pkg::reg_addr_t want_reg;
        mips_isa_pkg::word_t     want_data;
        int                      pulses;
        int                      errs;
        errs   = 0;
        pulses = $countones({wb_valid, exc_reserved, exc_overflow});
        if (pulses > 1) begin
            $display("ERROR at %0t ns: more than one outcome pulse in one cycle", $time);
            errs++;
        end else if (pulses == 1) begin
            kind = wb_valid ? "W" : (exc_reserved ? "R" : "O");
            if (kind_q.size() == 0) begin
                $display("ERROR at %0t ns: outcome %s arrived with no instruction in flight",
                         $time, kind);
                errs++;
            end else begin
                want_kind = kind_q.pop_front();
                want_reg  = reg_q.pop_front();
                want_data = data_q.pop_front();
                if (kind != want_kind) begin
                    $display("CHECK FAILED at %0t ns: outcome kind = %s, expected %s",
                             $time, kind, want_kind);
                    errs++;
                end else if (kind == "W") begin
                    if (wb_reg != want_reg) begin
                        $display("CHECK FAILED at %0t ns: wb_reg = %0d, expected %0d",
                                 $time, wb_reg, want_reg);
                        errs++;
                    end
                    if (wb_data != want_data) begin
                        $display("CHECK FAILED at %0t ns: wb_data = %h, expected %h",
                                 $time, wb_data, want_data);
                        errs++;
                    end
                end
                $display("test %0d: %s r%0d %h %s", done_count + 1, want_kind, want_reg,
                         want_data, (errs == 0) ? "ok" : "FAILED");
                done_count <= done_count + 1;
            end
        end
        if (exp_push) begin
            kind_q.push_back(exp_kind);
            reg_q.push_back(exp_reg);
            data_q.push_back(exp_data);
        end
        err_count <= err_count + errs;
    end

endmodule

// ==== int_exec_core_tb.sv ====
module int_exec_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 4;
    localparam logic [31:0] SEED         = 32'h0782447b;

    logic                    clk;
    logic                    arst_n;
    logic                    instr_valid;
    mips_isa_pkg::word_t     instr;
    logic                    wb_valid;
    mips_isa_pkg::reg_addr_t wb_reg;
    mips_isa_pkg::word_t     wb_data;
    logic                    exc_reserved;
    logic                    exc_overflow;

    logic                    exp_push;
    logic [7:0]              exp_kind;
    mips_isa_pkg::reg_addr_t exp_reg;
    mips_isa_pkg::word_t     exp_data;
    int                      done_count;
    int                      err_count;

    // one entry per data file line
    mips_isa_pkg::word_t     vec_instr [$];
    logic [7:0]              vec_kind [$];
    mips_isa_pkg::reg_addr_t vec_reg [$];
    mips_isa_pkg::word_t     vec_data [$];
    int                      num_tests;
    logic                    load_done;

    int_exec_core int_exec_core_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .exc_reserved (exc_reserved),
        .exc_overflow (exc_overflow)
    );

    exec_checker exec_checker_inst (
        .clk          (clk),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .exc_reserved (exc_reserved),
        .exc_overflow (exc_overflow),
        .exp_push     (exp_push),
        .exp_kind     (exp_kind),
        .exp_reg      (exp_reg),
        .exp_data     (exp_data),
        .done_count   (done_count),
        .err_count    (err_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_vectors(output bit ok);
        int                  fd;
        string               line;
        string               kind_str;
        mips_isa_pkg::word_t ins;
        int                  rnum;
        mips_isa_pkg::word_t data;
        ok = 1'b0;
        fd = $fopen("int_exec_core_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not scan as four fields
                if ($sscanf(line, "%h %s %d %h", ins, kind_str, rnum, data) == 4) begin
                    vec_instr.push_back(ins);
                    vec_kind.push_back(kind_str[0]);
                    vec_reg.push_back(rnum[4:0]);
                    vec_data.push_back(data);
                end
            end
            $fclose(fd);
            ok = (vec_instr.size() > 0);
        end
    endtask

    initial begin
        bit ok;
        int gap;
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        exp_push    = 1'b0;
        exp_kind    = '0;
        exp_reg     = '0;
        exp_data    = '0;
        num_tests   = 0;
        load_done   = 1'b0;
        void'($urandom(SEED));
        load_vectors(ok);
        if (!ok) begin
            $display("no test vectors could be read from int_exec_core_testdata.txt");
            $display("Checks failed");
            $finish;
        end else begin
            num_tests = vec_instr.size();
            load_done = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            arst_n <= 1'b1;
            @(posedge clk);
            for (int i = 0; i < num_tests; i++) begin
                // idle gap of 0 to 2 cycles before each instruction
                gap = $urandom_range(2, 0);
                repeat (gap) begin
                    @(posedge clk);
                    instr_valid <= 1'b0;
                    exp_push    <= 1'b0;
                end
                @(posedge clk);
                instr_valid <= 1'b1;
                instr       <= vec_instr[i];
                exp_push    <= 1'b1;
                exp_kind    <= vec_kind[i];
                exp_reg     <= vec_reg[i];
                exp_data    <= vec_data[i];
            end
            @(posedge clk);
            instr_valid <= 1'b0;
            exp_push    <= 1'b0;
            wait (done_count == num_tests);
            // a few more cycles to catch stray pulses
            repeat (4) @(posedge clk);
            $display("%0d of %0d tests done, %0d errors", done_count, num_tests,
                     err_count);
            if (err_count == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // each instruction needs at most 3 cycles of issue plus 2 of latency
    initial begin
        wait (load_done);
        #(num_tests * 6 * CLK_PERIOD + 200);
        $display("timeout, %0d of %0d expected outcomes never arrived",
                 num_tests - done_count, num_tests);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== int_exec_core_testdata.txt ====
# instr    kind  reg  data
# kind is W for writeback, R for reserved, O for overflow
3c011234 W 1 12340000
34215678 W 1 12345678
3c028000 W 2 80000000
3442ffff W 2 8000ffff
2403ffff W 3 ffffffff
20040005 W 4 00000005
00242821 W 5 1234567d
00813023 W 6 edcba98d
00223824 W 7 00005678
00224025 W 8 9234ffff
00234826 W 9 edcba987
00205027 W 10 edcba987
0064582a W 11 00000001
0064602b W 12 00000000
284d0000 W 13 00000001
2c8effff W 14 00000001
304ff0f0 W 15 0000f0f0
387000ff W 16 ffffff00
00018900 W 17 23456780
00029202 W 18 008000ff
00029a03 W 19 ff8000ff
0081a004 W 20 468acf00
0062a806 W 21 00000001
0082b007 W 22 fc0007ff
fc000000 R 0 00000000
00240801 R 0 00000000
34390000 W 25 12345678
00422820 O 0 00000000
34bb0000 W 27 1234567d
00223022 O 0 00000000
00c0f025 W 30 edcba98d
3c1c7fff W 28 7fff0000
379cffff W 28 7fffffff
239c0001 O 0 00000000
0380e821 W 29 7fffffff
24001234 W 0 00001234
0000f821 W 31 00000000

// ==== int_exec_core.f ====
mips_isa_pkg.sv
exec_ctrl_pkg.sv
instr_decode.sv
alu_execute.sv
reg_writeback.sv
int_exec_core.sv
exec_checker.sv
int_exec_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module int_exec_core_tb \
    -f int_exec_core.f -o int_exec_core_sim

out=$(./obj_dir/int_exec_core_sim)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
